// File: logic/vga_pkg.sv
package vga_pkg;

    // screen coordinate, wide enough for the 800 and 525 totals
    typedef logic [9:0] coord_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    // horizontal timing in pixel clocks
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;

    // vertical timing in lines
    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;

    // named colours
    localparam rgb_t C_BLACK = 12'h000;
    localparam rgb_t C_WHITE = 12'hfff;
    // background of the active area
    localparam rgb_t C_GREEN = 12'h0f0;
    // pressed keys
    localparam rgb_t C_CYAN  = 12'h0ff;
    // keyboard panel behind the keys
    localparam rgb_t C_GREY  = 12'h888;

endpackage

// File: logic/shape_pkg.sv
package shape_pkg;

    import vga_pkg::*;

    // object opcodes, NONE marks the end of the list
    typedef enum logic [1:0] {
        SHAPE_NONE      = 2'd0,
        SHAPE_RECT      = 2'd1,
        SHAPE_ROUNDRECT = 2'd2
    } shape_e;

    // one display object, 2 + 5*10 + 12 = 64 bits
    typedef struct packed {
        shape_e shape;
        coord_t x;
        coord_t y;
        coord_t w;
        coord_t h;
        coord_t r;
        rgb_t   colour;
    } obj_t;

    // 21 keys, then the panel, then the terminator
    localparam int N_KEYS = 21;
    localparam int N_OBJ  = 23;

    // key geometry, row 1 origin
    localparam coord_t KEY_X0    = 10'd80;
    localparam coord_t KEY_Y0    = 10'd120;
    localparam coord_t KEY_W     = 10'd40;
    localparam coord_t KEY_H     = 10'd40;
    localparam coord_t KEY_R     = 10'd5;
    localparam coord_t KEY_PITCH = 10'd50;

    // row offsets from row 1
    localparam coord_t ROW2_DX = 10'd30;
    localparam coord_t ROW2_DY = 10'd60;
    localparam coord_t ROW3_DX = 10'd40;
    localparam coord_t ROW3_DY = 10'd120;

    // grey panel behind all three rows
    localparam coord_t PANEL_X = 10'd60;
    localparam coord_t PANEL_Y = 10'd100;
    localparam coord_t PANEL_W = 10'd420;
    localparam coord_t PANEL_H = 10'd200;

    // key face colours
    localparam rgb_t KEY_UP_RGB   = C_WHITE;
    localparam rgb_t KEY_DOWN_RGB = C_CYAN;

endpackage

// File: logic/scan_if.sv
interface scan_if;

    import vga_pkg::*;

    // current scan position, raw counter values
    coord_t pix_x;
    coord_t pix_y;
    // inside the 640x480 window
    logic   video_on;
    // negative polarity syncs, not yet registered
    logic   hsync_n;
    logic   vsync_n;

    // timing generator side
    modport src (output pix_x, pix_y, video_on, hsync_n, vsync_n);
    // composer side
    modport dst (input pix_x, pix_y, video_on, hsync_n, vsync_n);

endinterface

// File: logic/vga_timing.sv
module vga_timing #(
    parameter int H_ACTIVE = vga_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = vga_pkg::DEF_H_SYNC,
    parameter int H_BACK   = vga_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = vga_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = vga_pkg::DEF_V_SYNC,
    parameter int V_BACK   = vga_pkg::DEF_V_BACK
) (
    input  logic   vga_clk,
    input  logic   rst,
    scan_if.src    scan
);

    import vga_pkg::*;

    // totals, 800 x 525 by default
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // last count before wrap
    localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

    // sync pulse windows, start inclusive and end exclusive
    localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t h_cnt;
    coord_t v_cnt;

    // pixel counter every clock, line counter on pixel wrap
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // position straight from the counters
    assign scan.pix_x = h_cnt;
    assign scan.pix_y = v_cnt;

    // active window, both counters in range
    assign scan.video_on = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

    // low during the pulse window
    assign scan.hsync_n = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
    assign scan.vsync_n = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

endmodule

// File: logic/key_layout.sv
module key_layout (
    input  logic                         vga_clk,
    input  logic                         rst,
    input  logic [shape_pkg::N_KEYS-1:0] key_down,
    output shape_pkg::obj_t              objs [shape_pkg::N_OBJ]
);

    import vga_pkg::*;
    import shape_pkg::*;

    localparam int KEYS_PER_ROW = 7;

    // fixed entries after the keys
    localparam obj_t PANEL_OBJ = '{shape: SHAPE_RECT, x: PANEL_X, y: PANEL_Y,
                                   w: PANEL_W, h: PANEL_H, r: '0, colour: C_GREY};
    localparam obj_t NONE_OBJ  = '{shape: SHAPE_NONE, x: '0, y: '0,
                                   w: '0, h: '0, r: '0, colour: C_BLACK};

    // build key idx from its row and column
    function automatic obj_t key_obj(input int idx, input logic down);
        int   row;
        int   col;
        obj_t o;
        row      = idx / KEYS_PER_ROW;
        col      = idx % KEYS_PER_ROW;
        o.shape  = SHAPE_ROUNDRECT;
        o.x      = KEY_X0 + coord_t'(col * KEY_PITCH);
        o.y      = KEY_Y0;
        o.w      = KEY_W;
        o.h      = KEY_H;
        o.r      = KEY_R;
        o.colour = down ? KEY_DOWN_RGB : KEY_UP_RGB;
        // shift rows 2 and 3 right and down
        case (row)
            1: begin
                o.x = o.x + ROW2_DX;
                o.y = KEY_Y0 + ROW2_DY;
            end
            2: begin
                o.x = o.x + ROW3_DX;
                o.y = KEY_Y0 + ROW3_DY;
            end
            default: o.y = KEY_Y0;
        endcase
        return o;
    endfunction

    // table reloaded every clock, key colour follows key_down
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            // all keys released
            for (int i = 0; i < N_KEYS; i++) begin
                objs[i] <= key_obj(i, 1'b0);
            end
            objs[N_KEYS]     <= PANEL_OBJ;
            objs[N_KEYS + 1] <= NONE_OBJ;
        end else begin
            for (int i = 0; i < N_KEYS; i++) begin
                objs[i] <= key_obj(i, key_down[i]);
            end
            objs[N_KEYS]     <= PANEL_OBJ;
            objs[N_KEYS + 1] <= NONE_OBJ;
        end
    end

endmodule

// File: logic/shape_hit.sv
module shape_hit (
    input  vga_pkg::coord_t px,
    input  vga_pkg::coord_t py,
    input  shape_pkg::obj_t obj,
    output logic            hit
);

    import vga_pkg::*;
    import shape_pkg::*;

    // distance along one axis
    function automatic logic [10:0] abs_diff(input logic [10:0] a, input logic [10:0] b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    function automatic logic [22:0] sq(input logic [10:0] d);
        return 23'(d) * 23'(d);
    endfunction

    // 11 bits so x + w cannot wrap
    logic [10:0] pxe, pye;
    logic [10:0] x0, x1, y0, y1;
    // rectangle inset by r, also the corner circle centres
    logic [10:0] xi0, xi1, yi0, yi1;
    logic [10:0] dx_l, dx_r, dy_t, dy_b;
    logic [22:0] r_sq;
    logic        in_rect, band_h, band_v, in_corner, degenerate;

    assign pxe = {1'b0, px};
    assign pye = {1'b0, py};
    assign x0  = {1'b0, obj.x};
    assign y0  = {1'b0, obj.y};
    assign x1  = x0 + {1'b0, obj.w};
    assign y1  = y0 + {1'b0, obj.h};
    assign xi0 = x0 + {1'b0, obj.r};
    assign yi0 = y0 + {1'b0, obj.r};
    assign xi1 = x1 - {1'b0, obj.r};
    assign yi1 = y1 - {1'b0, obj.r};

    // plain rectangle and the two cross bands
    assign in_rect = (pxe >= x0) && (pxe < x1) && (pye >= y0) && (pye < y1);
    assign band_h  = (pxe >= xi0) && (pxe < xi1) && (pye >= y0) && (pye < y1);
    assign band_v  = (pxe >= x0) && (pxe < x1) && (pye >= yi0) && (pye < yi1);

    // squared distance to each corner centre
    assign dx_l = abs_diff(pxe, xi0);
    assign dx_r = abs_diff(pxe, xi1);
    assign dy_t = abs_diff(pye, yi0);
    assign dy_b = abs_diff(pye, yi1);
    assign r_sq = sq({1'b0, obj.r});

    assign in_corner = (sq(dx_l) + sq(dy_t) < r_sq) || (sq(dx_r) + sq(dy_t) < r_sq) ||
                       (sq(dx_l) + sq(dy_b) < r_sq) || (sq(dx_r) + sq(dy_b) < r_sq);

    // radius too large for the box, never drawn
    assign degenerate = ({obj.r, 1'b0} >= {1'b0, obj.w}) || ({obj.r, 1'b0} >= {1'b0, obj.h});

    always_comb begin
        case (obj.shape)
            SHAPE_RECT:      hit = in_rect;
            SHAPE_ROUNDRECT: hit = !degenerate && (band_h || band_v || in_corner);
            default:         hit = 1'b0;
        endcase
    end

endmodule

// File: logic/pixel_composer.sv
module pixel_composer (
    input  logic            vga_clk,
    input  logic            rst,
    scan_if.dst             scan,
    input  shape_pkg::obj_t objs [shape_pkg::N_OBJ],
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue,
    output logic            hsync,
    output logic            vsync
);

    import vga_pkg::*;
    import shape_pkg::*;

    logic [N_OBJ-1:0] hits;
    logic             found;
    rgb_t             pix_rgb;

    // one containment test per list slot
    for (genvar i = 0; i < N_OBJ; i++) begin : g_hit
        shape_hit u_hit (
            .px  (scan.pix_x),
            .py  (scan.pix_y),
            .obj (objs[i]),
            .hit (hits[i])
        );
    end

    // first hit wins, NONE stops the walk with background
    always_comb begin
        found   = 1'b0;
        pix_rgb = C_GREEN;
        for (int i = 0; i < N_OBJ; i++) begin
            if (!found) begin
                if (objs[i].shape == SHAPE_NONE) begin
                    found   = 1'b1;
                    pix_rgb = C_GREEN;
                end else if (hits[i]) begin
                    found   = 1'b1;
                    pix_rgb = objs[i].colour;
                end
            end
        end
        // blanking is always black
        if (!scan.video_on) begin
            pix_rgb = C_BLACK;
        end
    end

    // colour and syncs share one register stage so they stay aligned
    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            {red, green, blue} <= '0;
            hsync              <= 1'b1;
            vsync              <= 1'b1;
        end else begin
            {red, green, blue} <= pix_rgb;
            hsync              <= scan.hsync_n;
            vsync              <= scan.vsync_n;
        end
    end

endmodule

// File: logic/kbd_vga_top.sv
module kbd_vga_top #(
    parameter int H_ACTIVE = vga_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = vga_pkg::DEF_H_SYNC,
    parameter int H_BACK   = vga_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = vga_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = vga_pkg::DEF_V_SYNC,
    parameter int V_BACK   = vga_pkg::DEF_V_BACK
) (
    input  logic                         vga_clk,
    input  logic                         rst,
    input  logic [shape_pkg::N_KEYS-1:0] key_down,
    output logic                         hsync,
    output logic                         vsync,
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue
);

    import shape_pkg::*;

    // object table from layout to composer
    obj_t objs [N_OBJ];

    scan_if scan ();

    // counters and sync decode
    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_timing (
        .vga_clk (vga_clk),
        .rst     (rst),
        .scan    (scan.src)
    );

    key_layout u_layout (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .key_down (key_down),
        .objs     (objs)
    );

    // one cycle from counter to pins
    pixel_composer u_composer (
        .vga_clk (vga_clk),
        .rst     (rst),
        .scan    (scan.dst),
        .objs    (objs),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .hsync   (hsync),
        .vsync   (vsync)
    );

endmodule

// File: verif/kbd_vga_chk.sv
module kbd_vga_chk (
    input logic       vga_clk,
    input logic       rst,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    import vga_pkg::*;

    localparam int H_TOTAL = DEF_H_ACTIVE + DEF_H_FRONT + DEF_H_SYNC + DEF_H_BACK;

    // length of the current low pulse
    int h_low;
    int v_low;
    // number of assertion failures so far
    int fail_cnt = 0;

    always_ff @(posedge vga_clk or negedge rst) begin
        if (!rst) begin
            h_low <= 0;
            v_low <= 0;
        end else begin
            h_low <= hsync ? 0 : h_low + 1;
            v_low <= vsync ? 0 : v_low + 1;
        end
    end

    // pulse length checked when the sync returns high
    a_hsync_width: assert property (@(posedge vga_clk) disable iff (!rst)
        $rose(hsync) |-> h_low == DEF_H_SYNC)
        else begin
            $error("hsync low pulse lasted %0d cycles", h_low);
            fail_cnt++;
        end

    // two full lines
    a_vsync_width: assert property (@(posedge vga_clk) disable iff (!rst)
        $rose(vsync) |-> v_low == DEF_V_SYNC * H_TOTAL)
        else begin
            $error("vsync low pulse lasted %0d cycles", v_low);
            fail_cnt++;
        end

    // sync pulses lie inside blanking
    a_black_in_sync: assert property (@(posedge vga_clk) disable iff (!rst)
        (!hsync || !vsync) |-> {red, green, blue} == 12'h000)
        else begin
            $error("colour not black during a sync pulse");
            fail_cnt++;
        end

endmodule

bind kbd_vga_top kbd_vga_chk u_chk (
    .vga_clk (vga_clk),
    .rst     (rst),
    .hsync   (hsync),
    .vsync   (vsync),
    .red     (red),
    .green   (green),
    .blue    (blue)
);

// File: verif/kbd_vga_tb.sv
module kbd_vga_tb;

    import vga_pkg::*;
    import shape_pkg::*;

    // one line and one frame in pixel clocks
    localparam int H_TOTAL = DEF_H_ACTIVE + DEF_H_FRONT + DEF_H_SYNC + DEF_H_BACK;
    localparam int V_TOTAL = DEF_V_ACTIVE + DEF_V_FRONT + DEF_V_SYNC + DEF_V_BACK;
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    localparam int RST_CYC = 10;
    // three frames cover the whole table
    localparam int LIMIT   = 3 * FRAME + RST_CYC;
    localparam int N_VEC   = 18;

    typedef struct {
        int                frame;
        logic [N_KEYS-1:0] mask;
        int                x;
        int                y;
        rgb_t              rgb;
    } vec_t;

    // raster order, key_down changes only between frames
    vec_t vecs [N_VEC] = '{
        '{0, 21'h000000,  20,  20, C_GREEN},
        '{0, 21'h000000, 700,  50, C_BLACK},
        '{0, 21'h000000,  80, 120, C_GREY},
        '{0, 21'h000000,  82, 122, C_WHITE},
        '{0, 21'h000000, 100, 140, C_WHITE},
        '{0, 21'h000000, 125, 140, C_GREY},
        // keys 0, 9 and 20 held down
        '{1, 21'h100201,  80, 120, C_GREY},
        '{1, 21'h100201, 100, 140, C_CYAN},
        '{1, 21'h100201, 150, 140, C_WHITE},
        '{1, 21'h100201, 210, 180, C_GREY},
        '{1, 21'h100201, 180, 200, C_WHITE},
        '{1, 21'h100201, 230, 200, C_CYAN},
        '{1, 21'h100201, 390, 260, C_WHITE},
        '{1, 21'h100201, 440, 260, C_CYAN},
        '{1, 21'h100201, 459, 279, C_GREY},
        // all released again
        '{2, 21'h000000, 100, 140, C_WHITE},
        '{2, 21'h000000, 230, 200, C_WHITE},
        '{2, 21'h000000, 440, 260, C_WHITE}
    };

    logic              vga_clk;
    logic              rst;
    logic [N_KEYS-1:0] key_down;
    logic              hsync;
    logic              vsync;
    logic [3:0]        red;
    logic [3:0]        green;
    logic [3:0]        blue;

    int   err_rgb = 0;
    int   err_sync = 0;
    int   err_time = 0;
    int   err_other = 0;
    // failures of the bound assertions
    int   err_assert = 0;
    // rising edges since reset release, main process only
    int   edge_cnt = 0;
    int   cyc_total = 0;
    // sync edge monitor state
    int   ncnt = 0;
    int   h_fall = 0;
    int   h_falls = 0;
    int   v_fall = 0;
    int   v_falls = 0;
    logic h_prev = 1'b1;
    logic v_prev = 1'b1;

    kbd_vga_top dut (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .key_down (key_down),
        .hsync    (hsync),
        .vsync    (vsync),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    initial vga_clk = 1'b0;
    always #5 vga_clk = ~vga_clk;

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t got);
        if (got !== exp) begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            err_rgb++;
        end
    endtask

    task automatic check_sync(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            err_sync++;
        end
    endtask

    task automatic compare_interval(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            err_time++;
        end
    endtask

    // step to the given edge count after release
    task automatic advance_to(input int n);
        while (edge_cnt < n) begin
            @(posedge vga_clk);
            edge_cnt++;
        end
    endtask

    // spacing of sync falls and hsync pulse width
    always @(negedge vga_clk) begin
        ncnt = ncnt + 1;
        if (rst) begin
            if (h_prev && !hsync) begin
                if (h_falls > 0)
                    compare_interval("hsync period", H_TOTAL, ncnt - h_fall);
                h_fall  = ncnt;
                h_falls = h_falls + 1;
            end
            if (!h_prev && hsync && h_falls > 0)
                compare_interval("hsync low width", DEF_H_SYNC, ncnt - h_fall);
            if (v_prev && !vsync) begin
                if (v_falls > 0)
                    compare_interval("vsync period", FRAME, ncnt - v_fall);
                v_fall  = ncnt;
                v_falls = v_falls + 1;
            end
        end
        h_prev = hsync;
        v_prev = vsync;
    end

    always @(posedge vga_clk) begin
        cyc_total++;
        if (cyc_total >= LIMIT) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cyc_total);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int n;
        rst      = 1'b0;
        key_down = '0;
        // outputs held black with syncs idle through reset
        repeat (RST_CYC) begin
            @(posedge vga_clk);
            #1;
            check_rgb("rgb in reset", C_BLACK, {red, green, blue});
            check_sync("hsync in reset", 1'b1, hsync);
            check_sync("vsync in reset", 1'b1, vsync);
        end
        rst = 1'b1;
        @(negedge vga_clk);
        check_rgb("rgb after release", C_BLACK, {red, green, blue});
        // syncs idle over the first pixels of line 0
        for (int k = 1; k <= 4; k++) begin
            advance_to(k);
            @(negedge vga_clk);
            check_sync("hsync after release", 1'b1, hsync);
            check_sync("vsync after release", 1'b1, vsync);
        end
        for (int i = 0; i < N_VEC; i++) begin
            // new mask during vertical blanking of the frame before
            if (vecs[i].mask !== key_down) begin
                advance_to(vecs[i].frame * FRAME - 20 * H_TOTAL);
                #1 key_down = vecs[i].mask;
            end
            n = vecs[i].frame * FRAME + vecs[i].y * H_TOTAL + vecs[i].x;
            // pixel n reaches the pins one edge after the counter
            advance_to(n + 1);
            @(negedge vga_clk);
            check_rgb($sformatf("rgb frame %0d (%0d,%0d)", vecs[i].frame, vecs[i].x, vecs[i].y),
                      vecs[i].rgb, {red, green, blue});
        end
        if (h_falls < 2 || v_falls < 2) begin
            $display("too few sync pulses seen: %0d hsync and %0d vsync", h_falls, v_falls);
            err_other++;
        end
        err_assert = dut.u_chk.fail_cnt;
        $display("errors: rgb %0d, sync %0d, timing %0d, assertion %0d, other %0d",
                 err_rgb, err_sync, err_time, err_assert, err_other);
        if (err_rgb + err_sync + err_time + err_assert + err_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
logic/vga_pkg.sv
logic/shape_pkg.sv
logic/scan_if.sv
logic/vga_timing.sv
logic/key_layout.sv
logic/shape_hit.sv
logic/pixel_composer.sv
logic/kbd_vga_top.sv
verif/kbd_vga_chk.sv
verif/kbd_vga_tb.sv
